/* vlog.f */
verilog/relay_pkg.sv
verilog/control_if.sv
verilog/sequencer.sv
verilog/decode_logic.sv
verilog/datapath.sv
verilog/relay_cpu.sv
sim/relay_cpu_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP = relay_cpu_tb
FILELIST = vlog.f
OBJ_DIR = obj_dir
PASS_MSG = Testbench passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

/* sim/relay_cpu_tb.sv */
//////////////////////////////////////////////////
// testbench for the relay cpu core
// clock, reset, memory model, program builder,
// directed tests and result checks
//////////////////////////////////////////////////
`timescale 1ns/1ns
module relay_cpu_tb;
	import relay_pkg::*;

	logic clk;
	logic reset;
	logic [15:0] mem_addr;
	logic [7:0] mem_wdata;
	logic [7:0] mem_rdata;
	logic mem_read;
	logic mem_write;
	logic halt;
	logic [7:0] mem [0:65535];
	logic poke_en; // program loading port
	logic [15:0] poke_addr;
	logic [7:0] poke_data;
	logic [15:0] prog_ptr;
	logic [31:0] lfsr;
	logic [15:0] exp_addr [$];
	logic [7:0] exp_data [$];
	int errors;
	int checks;

	relay_cpu i_relay_cpu (
		.clk(clk),
		.reset(reset),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.halt(halt),
		.mem_rdata(mem_rdata)
	);

	always #10 clk = ~clk;

	assign mem_rdata = (mem_read === 1'b1) ? mem[mem_addr] : 8'h00;

	always @(posedge clk)
	begin
		if (mem_write)
			mem[mem_addr] <= mem_wdata;
		else if (poke_en)
			mem[poke_addr] <= poke_data;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] v);
		return v[0] ? (v >> 1) ^ 32'hB4BCD35C : v >> 1;
	endfunction

	function automatic logic [7:0] sext5(input logic [4:0] v);
		return {{3{v[4]}}, v};
	endfunction

	function automatic logic [7:0] setab_byte(input logic to_b, input logic [4:0] imm);
		return {op_setab, to_b, imm};
	endfunction

	function automatic logic [7:0] mov8_byte(input reg_sel_t dst, input reg_sel_t src);
		return {op_mov8, dst, src};
	endfunction

	function automatic logic [7:0] alu_byte(input logic to_d, input alu_fn_t fn);
		return {op_alu, to_d, fn};
	endfunction

	function automatic logic [7:0] ldst_byte(input logic store, input logic [1:0] rs);
		return {op_ldst, store, 1'b0, rs};
	endfunction

	function automatic logic [7:0] mov16_byte(input logic xy, input logic j);
		return {op_mov16, xy, j, 2'b00};
	endfunction

	// carry in bit 8, only add and inc produce one
	function automatic logic [8:0] alu_model(input alu_fn_t fn, input logic [7:0] b,
		input logic [7:0] c);
		case (fn)
			alu_add: return {1'b0, b} + {1'b0, c};
			alu_inc: return {1'b0, b} + 9'd1;
			alu_and: return {1'b0, b & c};
			alu_or: return {1'b0, b | c};
			alu_xor: return {1'b0, b ^ c};
			alu_not: return {1'b0, ~b};
			alu_shl: return {1'b0, b[6:0], b[7]}; // rotate, bit 7 wraps
			default: return {1'b0, b};
		endcase
	endfunction

	function automatic logic branch_taken(input logic [3:0] cond, input logic z,
		input logic cy_flag, input logic sg);
		return cond[2:0] == goto_code || (cond[0] && !z) || (cond[1] && z)
			|| (cond[2] && !cy_flag) || (cond[3] && sg);
	endfunction

	task automatic next_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		checks++;
		if (got !== expected)
		begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic report_and_finish();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	endtask

	task automatic poke_mem(input logic [15:0] addr, input logic [7:0] data);
		poke_addr = addr;
		poke_data = data;
		poke_en = 1'b1;
		@(posedge clk);
		#2;
		poke_en = 1'b0;
	endtask

	task automatic place_byte(input logic [7:0] data);
		poke_mem(prog_ptr, data);
		prog_ptr++;
	endtask

	task automatic branch_to(input logic [3:0] cond, input logic j, input logic [15:0] target);
		place_byte({op_goto, j, 1'b0, cond});
		place_byte(target[15:8]);
		place_byte(target[7:0]);
	endtask

	task automatic point_m(input logic [15:0] addr);
		branch_to(4'b0000, 1'b0, addr); // never taken, bytes land in m1:m2
	endtask

	task automatic point_j(input logic [15:0] addr);
		branch_to(4'b0000, 1'b1, addr);
	endtask

	// cell starts as the complement so a missing store shows
	task automatic expect_mem(input logic [15:0] addr, input logic [7:0] value);
		exp_addr.push_back(addr);
		exp_data.push_back(value);
		poke_mem(addr, ~value);
	endtask

	// taken path stores b, fall through stores c
	task automatic probe_branch(input logic [3:0] cond, input logic [15:0] r,
		input logic [7:0] expected);
		logic [15:0] base;
		base = prog_ptr;
		branch_to(cond, 1'b1, base + 16'd10);
		point_m(r);
		place_byte(ldst_byte(1'b1, 2'd2));
		branch_to({1'b0, goto_code}, 1'b1, base + 16'd14);
		point_m(r);
		place_byte(ldst_byte(1'b1, 2'd1));
		expect_mem(r, expected);
	endtask

	task automatic probe_flags(input logic [15:0] r, input logic [7:0] b, input logic [7:0] c,
		input logic z, input logic cy_flag, input logic sg);
		logic [3:0] cond;
		for (int k = 0; k < 5; k++)
		begin
			cond = (k < 4) ? 4'(1 << k) : {1'b0, goto_code};
			probe_branch(cond, r + 16'(k), branch_taken(cond, z, cy_flag, sg) ? b : c);
		end
	endtask

	task automatic start_program();
		reset = 1'b1;
		prog_ptr = 16'h0000;
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic wait_halt(input int limit);
		int n;
		n = 0;
		while (!halt && n < limit)
		begin
			@(posedge clk);
			#2;
			n++;
		end
		if (!halt)
		begin
			$display("timeout: halt not raised within %0d cycles", limit);
			errors++;
			report_and_finish();
		end
	endtask

	task automatic run_program(input int limit);
		repeat (5)
		begin
			@(posedge clk);
			#2;
		end
		reset = 1'b0;
		wait_halt(limit);
		for (int i = 0; i < exp_addr.size(); i++)
			check_value($sformatf("mem[%h]", exp_addr[i]), {8'h00, mem[exp_addr[i]]},
				{8'h00, exp_data[i]});
	endtask

	task automatic setab_mov8_test();
		logic [15:0] r;
		logic [4:0] imm;
		logic to_b;
		for (int k = 0; k < 4; k++)
		begin
			next_bits(5, r);
			imm = r[4:0];
			next_bits(1, r);
			to_b = r[0];
			start_program();
			place_byte(setab_byte(to_b, imm));
			place_byte(mov8_byte(reg_c, to_b ? reg_b : reg_a));
			place_byte(mov8_byte(reg_x, reg_c));
			place_byte(mov8_byte(reg_y, reg_x));
			place_byte(mov8_byte(reg_d, reg_y));
			point_m(16'h0F00 + 16'(k));
			place_byte(ldst_byte(1'b1, 2'd3));
			place_byte(op_halt);
			expect_mem(16'h0F00 + 16'(k), sext5(imm));
			run_program(2000);
		end
	endtask

	task automatic alu_test();
		logic [15:0] r;
		logic [15:0] data;
		logic [15:0] out;
		logic [7:0] b;
		logic [7:0] c;
		logic [8:0] res;
		logic to_d;
		start_program();
		for (int f = 0; f < 7; f++)
		begin
			next_bits(8, r);
			b = r[7:0];
			next_bits(8, r);
			c = (r[7:0] == b) ? ~b : r[7:0]; // probes need b and c apart
			next_bits(1, r);
			to_d = r[0];
			data = 16'h8000 + 16'(2 * f);
			out = 16'h0E00 + 16'(8 * f);
			poke_mem(data, b);
			poke_mem(data + 16'd1, c);
			point_m(data);
			place_byte(ldst_byte(1'b0, 2'd1));
			point_m(data + 16'd1);
			place_byte(ldst_byte(1'b0, 2'd2));
			place_byte(alu_byte(to_d, alu_fn_t'(f)));
			point_m(out);
			place_byte(ldst_byte(1'b1, to_d ? 2'd3 : 2'd0));
			res = alu_model(alu_fn_t'(f), b, c);
			expect_mem(out, res[7:0]);
			probe_flags(out + 16'd1, b, c, res[7:0] == 8'd0, res[8], res[7]);
		end
		place_byte(op_halt);
		run_program(10000);
	endtask

	task automatic load_store_test();
		logic [15:0] r;
		logic [15:0] src;
		logic [15:0] dst;
		logic [7:0] v;
		logic [1:0] rs;
		for (int k = 0; k < 3; k++)
		begin
			next_bits(14, r);
			src = {2'b10, r[13:0]};
			next_bits(14, r);
			dst = {2'b11, r[13:0]};
			next_bits(8, r);
			v = r[7:0];
			next_bits(2, r);
			rs = r[1:0];
			start_program();
			poke_mem(src, v);
			expect_mem(dst, v);
			point_m(src);
			place_byte(ldst_byte(1'b0, rs));
			point_m(dst);
			place_byte(ldst_byte(1'b1, rs));
			place_byte(op_halt);
			run_program(2000);
		end
	endtask

	task automatic inc_mov16_test();
		logic [15:0] r;
		logic [15:0] ja;
		logic [15:0] xa;
		logic [4:0] imm;
		next_bits(8, r);
		ja = {8'h20, r[7:0]};
		next_bits(12, r);
		xa = {4'h4, r[11:0]};
		next_bits(5, r);
		imm = r[4:0];
		start_program();
		place_byte(setab_byte(1'b0, imm));
		point_j(ja);
		place_byte(mov16_byte(1'b0, 1'b1)); // pc from j
		prog_ptr = ja;
		point_m(xa);
		place_byte(mov16_byte(1'b1, 1'b0)); // xy from m
		place_byte({op_inc, 4'b0000});
		place_byte(op_return);
		poke_mem(xa, op_halt); // return without inc stops here
		prog_ptr = xa + 16'd1;
		point_m(16'h0F10);
		place_byte(ldst_byte(1'b1, 2'd0));
		place_byte(op_halt);
		expect_mem(16'h0F10, sext5(imm));
		run_program(2000);
	endtask

	task automatic goto_test();
		logic [7:0] v;
		logic [8:0] res;
		start_program();
		place_byte(setab_byte(1'b1, 5'h1F)); // b = ff, c stays 0
		place_byte(setab_byte(1'b0, 5'h00));
		v = sext5(5'h00);
		probe_flags(16'h0F20, 8'hFF, 8'h00, v == 8'd0, 1'b0, v[7]);
		place_byte(setab_byte(1'b0, 5'h10));
		v = sext5(5'h10);
		probe_flags(16'h0F28, 8'hFF, 8'h00, v == 8'd0, 1'b0, v[7]);
		place_byte(alu_byte(1'b1, alu_inc)); // ff + 1 into d
		res = alu_model(alu_inc, 8'hFF, 8'h00);
		probe_flags(16'h0F30, 8'hFF, 8'h00, res[7:0] == 8'd0, res[8], res[7]);
		place_byte(op_halt);
		run_program(6000);
	endtask

	task automatic halt_test();
		int reads;
		reads = 0;
		start_program();
		place_byte(setab_byte(1'b0, 5'd3));
		place_byte(op_halt);
		run_program(200);
		repeat (50)
		begin
			@(posedge clk);
			#2;
			if (mem_read)
				reads++;
		end
		check_value("mem_read cycles after halt", 16'(reads), 16'd0);
		check_value("halt", {15'd0, halt}, 16'd1);
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		poke_en = 1'b0;
		poke_addr = '0;
		poke_data = '0;
		prog_ptr = '0;
		lfsr = 32'h959a7bfa;
		errors = 0;
		checks = 0;
		@(posedge clk);
		#2;
		setab_mov8_test();
		alu_test();
		load_store_test();
		inc_mov16_test();
		goto_test();
		halt_test();
		report_and_finish();
	end
endmodule

/* verilog/relay_cpu.sv */
//////////////////////////////////////////////////
// relay cpu core top level
// sequencer, decoder and datapath on memory ports
//////////////////////////////////////////////////
`timescale 1ns/1ns
module relay_cpu (
	input logic clk,
	input logic reset,
	output logic [15:0] mem_addr,
	output logic [7:0] mem_wdata,
	output logic mem_read,
	output logic mem_write,
	output logic halt,
	input logic [7:0] mem_rdata
);
	import relay_pkg::*;

	state_t state;
	inst_class_t inst_class;
	inst_u inst;
	logic zero;
	logic carry;
	logic sign;

	control_if ctl (
		.clk(clk)
	);

	sequencer i_sequencer (
		.clk(clk),
		.reset(reset),
		.inst_class(inst_class),
		.halt_req(halt), // freezes state
		.state(state)
	);

	decode_logic i_decode_logic (
		.state(state),
		.inst(inst),
		.zero(zero),
		.carry(carry),
		.sign(sign),
		.inst_class(inst_class),
		.halt_req(halt),
		.ctl(ctl.decode)
	);

	datapath i_datapath (
		.clk(clk),
		.reset(reset),
		.mem_rdata(mem_rdata),
		.ctl(ctl.datapath),
		.inst(inst),
		.zero(zero),
		.carry(carry),
		.sign(sign),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_read(mem_read),
		.mem_write(mem_write)
	);
endmodule

/* verilog/datapath.sv */
//////////////////////////////////////////////////
// registers, alu, flags and incrementer
// data and address bus multiplexers
//////////////////////////////////////////////////
`timescale 1ns/1ns
module datapath (
	input logic clk,
	input logic reset,
	input logic [7:0] mem_rdata,
	control_if.datapath ctl,
	output relay_pkg::inst_u inst,
	output logic zero,
	output logic carry,
	output logic sign,
	output logic [15:0] mem_addr,
	output logic [7:0] mem_wdata,
	output logic mem_read,
	output logic mem_write
);
	import relay_pkg::*;

	logic [7:0] a, b, c, d, m1, m2, x, y, j1, j2;
	logic [15:0] pc;
	logic [15:0] inc; // incrementer latch
	logic [7:0] data_bus;
	logic [15:0] addr_bus;
	logic [7:0] alu_y;
	logic alu_carry;
	logic alu_active;

	assign alu_active = ctl.alu_fn != alu_nop;

	// alu inputs are always b and c
	always_comb
	begin
		alu_carry = 1'b0;
		case (ctl.alu_fn)
			alu_add: {alu_carry, alu_y} = {1'b0, b} + {1'b0, c};
			alu_inc: {alu_carry, alu_y} = {1'b0, b} + 9'd1;
			alu_and: alu_y = b & c;
			alu_or: alu_y = b | c;
			alu_xor: alu_y = b ^ c;
			alu_not: alu_y = ~b;
			alu_shl: alu_y = {b[6:0], b[7]}; // circular
			default: alu_y = b;
		endcase
	end

	always_comb
	begin
		case (1'b1)
			ctl.sel_a: data_bus = a;
			ctl.sel_b: data_bus = b;
			ctl.sel_c: data_bus = c;
			ctl.sel_d: data_bus = d;
			ctl.sel_m1: data_bus = m1;
			ctl.sel_m2: data_bus = m2;
			ctl.sel_x: data_bus = x;
			ctl.sel_y: data_bus = y;
			ctl.sel_imm: data_bus = ctl.imm_data;
			alu_active: data_bus = alu_y;
			ctl.mem_read_en: data_bus = mem_rdata;
			default: data_bus = '0;
		endcase
	end

	always_comb
	begin
		case (1'b1)
			ctl.sel_pc: addr_bus = pc;
			ctl.sel_m: addr_bus = {m1, m2};
			ctl.sel_xy: addr_bus = {x, y};
			ctl.sel_j: addr_bus = {j1, j2};
			ctl.sel_inc: addr_bus = inc;
			default: addr_bus = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			a <= '0;
			b <= '0;
			c <= '0;
			d <= '0;
			m1 <= '0;
			m2 <= '0;
			x <= '0;
			y <= '0;
			j1 <= '0;
			j2 <= '0;
			pc <= '0;
			inc <= '0;
			inst <= '0;
			zero <= 1'b0;
			carry <= 1'b0;
			sign <= 1'b0;
		end
		else
		begin
			if (ctl.ld_a) a <= data_bus;
			if (ctl.ld_b) b <= data_bus;
			if (ctl.ld_c) c <= data_bus;
			if (ctl.ld_d) d <= data_bus;
			if (ctl.ld_m1) m1 <= data_bus;
			if (ctl.ld_m2) m2 <= data_bus;
			if (ctl.ld_x) x <= data_bus;
			if (ctl.ld_y) y <= data_bus;
			if (ctl.ld_xy) {x, y} <= addr_bus;
			if (ctl.ld_j1) j1 <= data_bus;
			if (ctl.ld_j2) j2 <= data_bus;
			if (ctl.ld_pc) pc <= addr_bus;
			if (ctl.ld_inc) inc <= addr_bus + 16'd1;
			if (ctl.ld_inst) inst <= data_bus;
			if (ctl.ld_cond)
			begin
				zero <= data_bus == 8'd0; // alu result on alu ops
				sign <= data_bus[7];
				carry <= alu_carry;
			end
		end
	end

	assign mem_addr = addr_bus;
	assign mem_wdata = data_bus;
	assign mem_read = ctl.mem_read_en;
	assign mem_write = ctl.mem_write_en;

	a_no_read_write: assert property (@(posedge clk) disable iff (reset)
		!(mem_read && mem_write));
endmodule

/* verilog/decode_logic.sv */
//////////////////////////////////////////////////
// instruction decoder
// state and instruction byte to control strobes,
// instruction group and halt request
//////////////////////////////////////////////////
`timescale 1ns/1ns
module decode_logic (
	input relay_pkg::state_t state,
	input relay_pkg::inst_u inst,
	input logic zero,
	input logic carry,
	input logic sign,
	output relay_pkg::inst_class_t inst_class,
	output logic halt_req,
	control_if.decode ctl
);
	import relay_pkg::*;

	logic [7:0] ld_reg; // indexed by register code
	logic [7:0] sel_reg;
	logic is_mov8;
	logic is_setab;
	logic take_jump;

	// high from state first up to the state before clear
	function automatic logic span(input state_t now, input state_t first, input state_t clear);
		return now >= first && now < clear;
	endfunction

	assign is_mov8 = inst.mov8.op == op_mov8;
	assign is_setab = inst.setab.op == op_setab;
	assign halt_req = inst.raw == op_halt && state == st_9;
	assign ctl.imm_data = {{3{inst.setab.imm[4]}}, inst.setab.imm};

	assign take_jump = inst.goto.cond[2:0] == goto_code || inst.goto.cond[2:0] == call_code
		|| (inst.goto.cond[z0] && !zero) || (inst.goto.cond[z1] && zero)
		|| (inst.goto.cond[cy] && !carry) || (inst.goto.cond[s] && sign);

	always_comb
	begin
		if (inst.goto.op == op_goto)
			inst_class = cls_goto;
		else if (inst.ldst.op == op_ldst)
			inst_class = cls_ldst;
		else if (inst.mov16.op == op_mov16)
			inst_class = cls_mov16;
		else if (inst.alu.op == op_inc)
			inst_class = cls_inc;
		else
			inst_class = cls_short; // mov8, setab, alu
	end

	always_comb
	begin
		ld_reg = '0;
		sel_reg = '0;
		ctl.ld_j1 = 1'b0;
		ctl.ld_j2 = 1'b0;
		ctl.ld_xy = 1'b0;
		ctl.ld_cond = 1'b0;
		ctl.sel_m = 1'b0;
		ctl.sel_j = 1'b0;
		ctl.sel_xy = 1'b0;
		ctl.sel_imm = 1'b0;
		ctl.mem_write_en = 1'b0;
		ctl.alu_fn = alu_nop;
		ctl.sel_pc = span(state, st_1, st_4); // fetch
		ctl.mem_read_en = span(state, st_1, st_4);
		ctl.ld_inst = span(state, st_2, st_3);
		ctl.ld_inc = span(state, st_2, st_3);
		ctl.ld_pc = span(state, st_5, st_6); // pc past opcode
		ctl.sel_inc = span(state, st_5, st_7);
		case (inst_class)
			cls_short:
			begin
				if (is_mov8)
				begin
					ld_reg[inst.mov8.dst] = span(state, st_5, st_6);
					sel_reg[inst.mov8.src] = span(state, st_5, st_7);
				end
				else if (is_setab)
				begin
					ctl.sel_imm = span(state, st_4, st_7);
					ctl.ld_cond = span(state, st_5, st_6);
					ld_reg[inst.setab.to_b ? reg_b : reg_a] = span(state, st_5, st_6);
				end
				else
				begin
					if (span(state, st_4, st_7))
						ctl.alu_fn = inst.alu.fn;
					ctl.ld_cond = span(state, st_5, st_6);
					ld_reg[inst.alu.to_d ? reg_d : reg_a] = span(state, st_5, st_6);
				end
			end
			cls_ldst:
			begin
				ctl.sel_m = span(state, st_8, st_11);
				if (inst.ldst.store)
				begin
					sel_reg[{1'b0, inst.ldst.rs}] = span(state, st_8, st_11);
					ctl.mem_write_en = span(state, st_9, st_10); // single state
				end
				else
				begin
					if (span(state, st_8, st_10))
						ctl.mem_read_en = 1'b1;
					ld_reg[{1'b0, inst.ldst.rs}] = span(state, st_9, st_10);
				end
			end
			cls_inc:
			begin
				ctl.sel_xy = span(state, st_8, st_10);
				if (span(state, st_8, st_9))
					ctl.ld_inc = 1'b1; // xy + 1
				ctl.ld_xy = span(state, st_11, st_12);
				if (span(state, st_11, st_13))
					ctl.sel_inc = 1'b1;
			end
			cls_mov16:
			begin
				if (inst.raw == op_return)
				begin
					ctl.sel_xy = span(state, st_8, st_10);
					if (span(state, st_8, st_9))
						ctl.ld_pc = 1'b1;
				end
				else if (inst.raw != op_halt)
				begin
					ctl.sel_j = inst.mov16.j && span(state, st_8, st_10);
					ctl.sel_m = !inst.mov16.j && span(state, st_8, st_10);
					ctl.ld_xy = inst.mov16.xy && span(state, st_8, st_9);
					if (!inst.mov16.xy && span(state, st_8, st_9))
						ctl.ld_pc = 1'b1;
				end
			end
			cls_goto:
			begin
				if (span(state, st_8, st_11) || span(state, st_15, st_18))
				begin
					ctl.sel_pc = 1'b1; // address byte reads
					ctl.mem_read_en = 1'b1;
				end
				if (span(state, st_9, st_10) || span(state, st_16, st_17))
					ctl.ld_inc = 1'b1;
				if (span(state, st_12, st_13) || span(state, st_19, st_20)
					|| (take_jump && span(state, st_22, st_23)))
					ctl.ld_pc = 1'b1;
				if (span(state, st_12, st_14) || span(state, st_19, st_21))
					ctl.sel_inc = 1'b1;
				ctl.ld_j1 = inst.goto.j && span(state, st_9, st_10);
				ctl.ld_j2 = inst.goto.j && span(state, st_16, st_17);
				ld_reg[reg_m1] = !inst.goto.j && span(state, st_9, st_10);
				ld_reg[reg_m2] = !inst.goto.j && span(state, st_16, st_17);
				ctl.sel_j = take_jump && span(state, st_22, st_24);
			end
			default:
				ctl.alu_fn = alu_nop;
		endcase
		ctl.ld_a = ld_reg[reg_a];
		ctl.ld_b = ld_reg[reg_b];
		ctl.ld_c = ld_reg[reg_c];
		ctl.ld_d = ld_reg[reg_d];
		ctl.ld_m1 = ld_reg[reg_m1];
		ctl.ld_m2 = ld_reg[reg_m2];
		ctl.ld_x = ld_reg[reg_x];
		ctl.ld_y = ld_reg[reg_y];
		ctl.sel_a = sel_reg[reg_a];
		ctl.sel_b = sel_reg[reg_b];
		ctl.sel_c = sel_reg[reg_c];
		ctl.sel_d = sel_reg[reg_d];
		ctl.sel_m1 = sel_reg[reg_m1];
		ctl.sel_m2 = sel_reg[reg_m2];
		ctl.sel_x = sel_reg[reg_x];
		ctl.sel_y = sel_reg[reg_y];
	end

	a_one_data_source: assert property (@(posedge ctl.clk) $onehot0({ctl.sel_a, ctl.sel_b,
		ctl.sel_c, ctl.sel_d, ctl.sel_m1, ctl.sel_m2, ctl.sel_x, ctl.sel_y, ctl.sel_imm}));
endmodule

/* verilog/sequencer.sv */
//////////////////////////////////////////////////
// instruction state counter
// wraps at the group's last state, holds on halt
//////////////////////////////////////////////////
`timescale 1ns/1ns
module sequencer (
	input logic clk,
	input logic reset,
	input relay_pkg::inst_class_t inst_class,
	input logic halt_req,
	output relay_pkg::state_t state
);
	import relay_pkg::*;

	state_t last_state;

	always_comb
	begin
		case (inst_class)
			cls_ldst, cls_mov16: last_state = last_ldst;
			cls_inc: last_state = last_inc;
			cls_goto: last_state = last_goto;
			default: last_state = last_short;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= st_idle;
		else if (!halt_req)
		begin
			if (state == st_idle || state == last_state)
				state <= st_1; // next fetch
			else
				state <= state + 5'd1;
		end
	end

	a_state_range: assert property (@(posedge clk) state <= st_24);
endmodule

/* verilog/control_if.sv */
//////////////////////////////////////////////////
// control strobes from decoder to datapath
// loads, bus selects, alu and memory controls
//////////////////////////////////////////////////
`timescale 1ns/1ns
interface control_if (
	input logic clk
);
	import relay_pkg::*;

	logic ld_a, ld_b, ld_c, ld_d, ld_m1, ld_m2, ld_x, ld_y;
	logic ld_j1, ld_j2, ld_xy, ld_pc, ld_inc, ld_inst, ld_cond;
	logic sel_a, sel_b, sel_c, sel_d, sel_m1, sel_m2, sel_x, sel_y; // data bus
	logic sel_imm;
	logic sel_m, sel_j, sel_xy, sel_pc, sel_inc; // address bus
	alu_fn_t alu_fn;
	logic [7:0] imm_data;
	logic mem_read_en, mem_write_en;

	modport decode (
		input clk,
		output ld_a, ld_b, ld_c, ld_d, ld_m1, ld_m2, ld_x, ld_y,
		output ld_j1, ld_j2, ld_xy, ld_pc, ld_inc, ld_inst, ld_cond,
		output sel_a, sel_b, sel_c, sel_d, sel_m1, sel_m2, sel_x, sel_y, sel_imm,
		output sel_m, sel_j, sel_xy, sel_pc, sel_inc,
		output alu_fn, imm_data, mem_read_en, mem_write_en
	);

	modport datapath (
		input ld_a, ld_b, ld_c, ld_d, ld_m1, ld_m2, ld_x, ld_y,
		input ld_j1, ld_j2, ld_xy, ld_pc, ld_inc, ld_inst, ld_cond,
		input sel_a, sel_b, sel_c, sel_d, sel_m1, sel_m2, sel_x, sel_y, sel_imm,
		input sel_m, sel_j, sel_xy, sel_pc, sel_inc,
		input alu_fn, imm_data, mem_read_en, mem_write_en
	);
endinterface

/* verilog/relay_pkg.sv */
//////////////////////////////////////////////////
// shared definitions for the relay cpu core
// state numbers, opcode groups, alu and register
// codes, the instruction union
//////////////////////////////////////////////////
package relay_pkg;
	typedef logic [4:0] state_t;
	localparam state_t st_idle = 5'd0; // after reset
	localparam state_t st_1 = 5'd1;
	localparam state_t st_2 = 5'd2;
	localparam state_t st_3 = 5'd3;
	localparam state_t st_4 = 5'd4;
	localparam state_t st_5 = 5'd5;
	localparam state_t st_6 = 5'd6;
	localparam state_t st_7 = 5'd7;
	localparam state_t st_8 = 5'd8;
	localparam state_t st_9 = 5'd9;
	localparam state_t st_10 = 5'd10;
	localparam state_t st_11 = 5'd11;
	localparam state_t st_12 = 5'd12;
	localparam state_t st_13 = 5'd13;
	localparam state_t st_14 = 5'd14;
	localparam state_t st_15 = 5'd15;
	localparam state_t st_16 = 5'd16;
	localparam state_t st_17 = 5'd17;
	localparam state_t st_18 = 5'd18;
	localparam state_t st_19 = 5'd19;
	localparam state_t st_20 = 5'd20;
	localparam state_t st_21 = 5'd21;
	localparam state_t st_22 = 5'd22;
	localparam state_t st_23 = 5'd23;
	localparam state_t st_24 = 5'd24;

	localparam state_t last_short = 5'd8; // mov8, setab, alu
	localparam state_t last_ldst = 5'd11; // also mov16
	localparam state_t last_inc = 5'd14;
	localparam state_t last_goto = 5'd24;

	localparam logic [1:0] op_mov8 = 2'b00;
	localparam logic [1:0] op_setab = 2'b01;
	localparam logic [1:0] op_goto = 2'b11;
	localparam logic [3:0] op_alu = 4'b1000;
	localparam logic [3:0] op_ldst = 4'b1001;
	localparam logic [3:0] op_mov16 = 4'b1010;
	localparam logic [3:0] op_inc = 4'b1011;
	localparam logic [7:0] op_halt = 8'hAE;
	localparam logic [7:0] op_return = 8'hAA; // xy to pc
	localparam logic [2:0] goto_code = 3'b110;
	localparam logic [2:0] call_code = 3'b111;

	localparam int z0 = 0; // branch if not zero
	localparam int z1 = 1; // branch if zero
	localparam int cy = 2; // branch if no carry
	localparam int s = 3; // branch if sign

	typedef logic [2:0] inst_class_t;
	localparam inst_class_t cls_short = 3'd0;
	localparam inst_class_t cls_ldst = 3'd1;
	localparam inst_class_t cls_mov16 = 3'd2;
	localparam inst_class_t cls_inc = 3'd3;
	localparam inst_class_t cls_goto = 3'd4;

	typedef logic [2:0] alu_fn_t;
	localparam alu_fn_t alu_add = 3'd0;
	localparam alu_fn_t alu_inc = 3'd1;
	localparam alu_fn_t alu_and = 3'd2;
	localparam alu_fn_t alu_or = 3'd3;
	localparam alu_fn_t alu_xor = 3'd4;
	localparam alu_fn_t alu_not = 3'd5;
	localparam alu_fn_t alu_shl = 3'd6;
	localparam alu_fn_t alu_nop = 3'd7;

	typedef logic [2:0] reg_sel_t;
	localparam reg_sel_t reg_a = 3'd0;
	localparam reg_sel_t reg_b = 3'd1;
	localparam reg_sel_t reg_c = 3'd2;
	localparam reg_sel_t reg_d = 3'd3;
	localparam reg_sel_t reg_m1 = 3'd4;
	localparam reg_sel_t reg_m2 = 3'd5;
	localparam reg_sel_t reg_x = 3'd6;
	localparam reg_sel_t reg_y = 3'd7;

	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [1:0] op;
			reg_sel_t dst;
			reg_sel_t src;
		} mov8;
		struct packed {
			logic [1:0] op;
			logic to_b;
			logic [4:0] imm;
		} setab;
		struct packed {
			logic [3:0] op;
			logic to_d;
			alu_fn_t fn;
		} alu;
		struct packed {
			logic [3:0] op;
			logic store;
			logic pad;
			logic [1:0] rs; // a to d only
		} ldst;
		struct packed {
			logic [3:0] op;
			logic xy;
			logic j;
			logic [1:0] pad;
		} mov16;
		struct packed {
			logic [1:0] op;
			logic j; // address bytes into j, else m
			logic pad;
			logic [3:0] cond;
		} goto;
	} inst_u;
endpackage
